//--- src/valu_defines.svh
// sizing macros for the vector multiply-add unit, included by the RTL and the testbench
`ifndef VALU_DEFINES_SVH
`define VALU_DEFINES_SVH

// lanes per vector
`define VALU_NUM_ELEMS 4
// bits per lane
`define VALU_ELEM_W 16
`define VALU_VEC_W (`VALU_NUM_ELEMS * `VALU_ELEM_W)

// lane width after the multiplier, one extra bit per half element
`define VALU_PROD_W (`VALU_ELEM_W + 2)
// lane width after the adder, two guard bits per half element
`define VALU_SUM_W (`VALU_ELEM_W + 4)

// cycles from input strobe to result strobe
`define VALU_LATENCY 4

`endif

//--- src/valu_op_pkg.sv
// opcode encoding of the vector multiply-add instructions, imported by decode and top level
package valu_op_pkg;

  // ------------------------------------------------------------
  // instruction opcodes
  // ------------------------------------------------------------

  typedef enum logic [2:0] {
    // a * b
    VOP_MUL    = 3'b000,
    // a * b + accumulator
    VOP_MULA   = 3'b001,
    // a * b, also written to the accumulator
    VOP_MULTAC = 3'b010,
    // a + b
    VOP_ADD    = 3'b011,
    // a - b
    VOP_SUB    = 3'b100,
    // a + accumulator
    VOP_ADDAC  = 3'b101,
    // a copied into the accumulator
    VOP_MTAC   = 3'b110
  } vop_e;

  // the single unused encoding
  localparam logic [2:0] VOP_ILLEGAL_CODE = 3'b111;

endpackage

//--- src/valu_ctrl_pkg.sv
// decoded control bundles handed between the datapath stages of the multiply-add unit
package valu_ctrl_pkg;

  // one 16-bit element or two 8-bit elements per lane
  typedef enum logic {
    MODE_FULL = 1'b0,
    MODE_HALF = 1'b1
  } elem_mode_e;

  // second adder operand
  typedef enum logic [1:0] {
    ADDEND_ZERO  = 2'd0,
    ADDEND_B     = 2'd1,
    ADDEND_ACCUM = 2'd2
  } addend_sel_e;

  // ------------------------------------------------------------
  // per-stage bundles
  // ------------------------------------------------------------

  typedef struct packed {
    elem_mode_e  mode;
    addend_sel_e addend_sel;
    logic        negate_b;
  } add_ctrl_t;

  typedef struct packed {
    elem_mode_e mode;
    logic       saturate;
    logic       save_to_accum;
  } round_ctrl_t;

endpackage

//--- src/valu_decode.sv
// first pipeline stage, registers the operands and turns the opcode into stage controls
`include "valu_defines.svh"

module valu_decode import valu_op_pkg::*, valu_ctrl_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   in_valid,
  input  vop_e                   in_op,
  input  logic                   in_frac,
  input  logic                   in_half,
  input  logic [`VALU_VEC_W-1:0] in_a,
  input  logic [`VALU_VEC_W-1:0] in_b,
  output logic                   dec_valid,
  output logic [`VALU_VEC_W-1:0] dec_a,
  output logic [`VALU_VEC_W-1:0] dec_b,
  output logic                   mult_by_one,
  output logic                   mult_shift,
  output elem_mode_e             mode,
  output add_ctrl_t              add_ctrl,
  output round_ctrl_t            round_ctrl
);

  logic        next_by_one;
  logic        next_negate;
  logic        next_save;
  addend_sel_e next_addend;
  elem_mode_e  next_mode;

  assign next_mode = in_half ? MODE_HALF : MODE_FULL;

  // ------------------------------------------------------------
  // opcode decode
  // ------------------------------------------------------------

  always_comb begin
    next_by_one = 1'b0;
    next_negate = 1'b0;
    next_save   = 1'b0;
    next_addend = ADDEND_ZERO;
    case (in_op)
      VOP_MULA:   next_addend = ADDEND_ACCUM;
      VOP_MULTAC: next_save = 1'b1;
      VOP_ADD: begin
        next_by_one = 1'b1;
        next_addend = ADDEND_B;
      end
      VOP_SUB: begin
        next_by_one = 1'b1;
        next_addend = ADDEND_B;
        next_negate = 1'b1;
      end
      VOP_ADDAC: begin
        next_by_one = 1'b1;
        next_addend = ADDEND_ACCUM;
      end
      VOP_MTAC: begin
        next_by_one = 1'b1;
        next_save   = 1'b1;
      end
      // plain product, VOP_MUL
      default: next_addend = ADDEND_ZERO;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      dec_valid   <= 1'b0;
      mult_by_one <= 1'b0;
      mult_shift  <= 1'b0;
      mode        <= MODE_FULL;
      add_ctrl    <= '0;
      round_ctrl  <= '0;
    end else begin
      dec_valid   <= in_valid;
      mult_by_one <= next_by_one;
      // fractional scaling only for real products
      mult_shift  <= in_frac && !next_by_one;
      mode        <= next_mode;
      add_ctrl    <= '{mode: next_mode, addend_sel: next_addend, negate_b: next_negate};
      round_ctrl  <= '{mode: next_mode, saturate: in_frac,
                       save_to_accum: in_valid && next_save};
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      dec_a <= in_a;
      dec_b <= in_b;
    end
  end

  // no issue slot may carry the unused encoding
  assert property (@(posedge clk) disable iff (reset)
    in_valid |-> (in_op != VOP_ILLEGAL_CODE))
    else $error("illegal opcode issued");

endmodule

//--- src/ctrl_delay.sv
// reset-to-zero shift register that carries a control bundle in step with the datapath
module ctrl_delay #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 1
) (
  input  logic     clk,
  input  logic     reset,
  input  payload_t in,
  output payload_t out
);

  payload_t stages [DEPTH];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < DEPTH; i++) begin
        stages[i] <= '0;
      end
    end else begin
      stages[0] <= in;
      for (int i = 1; i < DEPTH; i++) begin
        stages[i] <= stages[i-1];
      end
    end
  end

  assign out = stages[DEPTH-1];

endmodule

//--- src/valu_mult.sv
// second pipeline stage, per-lane signed multiplier with pass-through of a and fractional scaling
`include "valu_defines.svh"

module valu_mult import valu_ctrl_pkg::*; (
  input  logic                                     clk,
  input  logic                                     reset,
  input  logic                                     dec_valid,
  input  logic [`VALU_VEC_W-1:0]                   dec_a,
  input  logic [`VALU_VEC_W-1:0]                   dec_b,
  input  logic                                     mult_by_one,
  input  logic                                     mult_shift,
  input  elem_mode_e                               mode,
  output logic                                     mul_valid,
  output logic [`VALU_NUM_ELEMS*`VALU_PROD_W-1:0]  mul_p,
  output logic [`VALU_VEC_W-1:0]                   mul_b
);

  localparam int W   = `VALU_ELEM_W;
  localparam int H   = `VALU_ELEM_W / 2;
  localparam int P_W = `VALU_PROD_W;

  wire [`VALU_NUM_ELEMS*P_W-1:0] p_next;

  for (genvar l = 0; l < `VALU_NUM_ELEMS; l++) begin : g_lane
    logic signed [W-1:0]   a_f;
    logic signed [W-1:0]   b_f;
    logic signed [2*W-1:0] p_f;
    logic signed [W:0]     r_f;
    logic signed [H-1:0]   a_h [2];
    logic signed [H-1:0]   b_h [2];
    logic signed [W-1:0]   p_h [2];
    logic signed [H:0]     r_h [2];

    always_comb begin
      a_f = dec_a[l*W +: W];
      b_f = dec_b[l*W +: W];
      p_f = a_f * b_f;
      // full element: keep q15 product bits or the wrapped low half
      if (mult_by_one) r_f = a_f;
      else if (mult_shift) r_f = p_f[2*W-1:W-1];
      else r_f = $signed(p_f[W-1:0]);
      // two independent byte elements
      for (int h = 0; h < 2; h++) begin
        a_h[h] = a_f[h*H +: H];
        b_h[h] = b_f[h*H +: H];
        p_h[h] = a_h[h] * b_h[h];
        if (mult_by_one) r_h[h] = a_h[h];
        else if (mult_shift) r_h[h] = p_h[h][W-1:H-1];
        else r_h[h] = $signed(p_h[h][H-1:0]);
      end
    end

    assign p_next[l*P_W +: P_W] = (mode == MODE_HALF) ? {r_h[1], r_h[0]} : {r_f[W], r_f};
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) mul_valid <= 1'b0;
    else mul_valid <= dec_valid;
  end

  always_ff @(posedge clk) begin
    mul_p <= p_next;
    mul_b <= dec_b;
  end

endmodule

//--- src/valu_add.sv
// third pipeline stage, adds zero, plus or minus b, or the forwarded accumulator to each product
`include "valu_defines.svh"

module valu_add import valu_ctrl_pkg::*; (
  input  logic                                    clk,
  input  logic                                    reset,
  input  logic                                    mul_valid,
  input  logic [`VALU_NUM_ELEMS*`VALU_PROD_W-1:0] mul_p,
  input  logic [`VALU_VEC_W-1:0]                  mul_b,
  input  add_ctrl_t                               add_ctrl,
  input  logic [`VALU_VEC_W-1:0]                  accum,
  input  logic                                    fwd_valid,
  input  logic [`VALU_VEC_W-1:0]                  fwd_value,
  output logic                                    add_valid,
  output logic [`VALU_NUM_ELEMS*`VALU_SUM_W-1:0]  add_sum
);

  localparam int W   = `VALU_ELEM_W;
  localparam int H   = `VALU_ELEM_W / 2;
  localparam int P_W = `VALU_PROD_W;
  localparam int S_W = `VALU_SUM_W;

  logic [`VALU_VEC_W-1:0] addend;
  wire  [`VALU_NUM_ELEMS*S_W-1:0] s_next;

  // a save still in the round stage wins over the stored accumulator
  always_comb begin
    case (add_ctrl.addend_sel)
      ADDEND_B:     addend = mul_b;
      ADDEND_ACCUM: addend = fwd_valid ? fwd_value : accum;
      default:      addend = '0;
    endcase
  end

  for (genvar l = 0; l < `VALU_NUM_ELEMS; l++) begin : g_lane
    logic signed [W:0]   e_f;
    logic signed [W+1:0] s_f;
    logic signed [H:0]   e_h [2];
    logic signed [H+1:0] s_h [2];

    always_comb begin
      e_f = $signed(addend[l*W +: W]);
      if (add_ctrl.negate_b) e_f = -e_f;
      s_f = $signed(mul_p[l*P_W +: W+1]) + e_f;
      for (int h = 0; h < 2; h++) begin
        e_h[h] = $signed(addend[l*W + h*H +: H]);
        if (add_ctrl.negate_b) e_h[h] = -e_h[h];
        s_h[h] = $signed(mul_p[l*P_W + h*(H+1) +: H+1]) + e_h[h];
      end
    end

    assign s_next[l*S_W +: S_W] = (add_ctrl.mode == MODE_HALF) ?
                                  {s_h[1], s_h[0]} : {{2{s_f[W+1]}}, s_f};
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) add_valid <= 1'b0;
    else add_valid <= mul_valid;
  end

  always_ff @(posedge clk) begin
    add_sum <= s_next;
  end

endmodule

//--- src/valu_round.sv
// last pipeline stage, saturates or wraps each element, holds the accumulator, drives the result
`include "valu_defines.svh"

module valu_round import valu_ctrl_pkg::*; (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic                                   add_valid,
  input  logic [`VALU_NUM_ELEMS*`VALU_SUM_W-1:0] add_sum,
  input  round_ctrl_t                            round_ctrl,
  output logic                                   result_valid,
  output logic [`VALU_VEC_W-1:0]                 result,
  output logic [`VALU_VEC_W-1:0]                 accum,
  output logic                                   fwd_valid,
  output logic [`VALU_VEC_W-1:0]                 fwd_value
);

  localparam int W     = `VALU_ELEM_W;
  localparam int H     = `VALU_ELEM_W / 2;
  localparam int S_W   = `VALU_SUM_W;
  localparam int F_MAX = 2**(W-1) - 1;
  localparam int F_MIN = -(2**(W-1));
  localparam int H_MAX = 2**(H-1) - 1;
  localparam int H_MIN = -(2**(H-1));

  wire [`VALU_VEC_W-1:0] rnd;

  // ------------------------------------------------------------
  // clamp or wrap per element
  // ------------------------------------------------------------

  for (genvar l = 0; l < `VALU_NUM_ELEMS; l++) begin : g_lane
    logic signed [W+1:0] s_f;
    logic [W-1:0]        r_f;
    logic signed [H+1:0] s_h [2];
    logic [H-1:0]        r_h [2];

    always_comb begin
      s_f = add_sum[l*S_W +: W+2];
      r_f = s_f[W-1:0];
      if (round_ctrl.saturate && s_f > F_MAX) r_f = F_MAX[W-1:0];
      if (round_ctrl.saturate && s_f < F_MIN) r_f = F_MIN[W-1:0];
      for (int h = 0; h < 2; h++) begin
        s_h[h] = add_sum[l*S_W + h*(H+2) +: H+2];
        r_h[h] = s_h[h][H-1:0];
        if (round_ctrl.saturate && s_h[h] > H_MAX) r_h[h] = H_MAX[H-1:0];
        if (round_ctrl.saturate && s_h[h] < H_MIN) r_h[h] = H_MIN[H-1:0];
      end
    end

    assign rnd[l*W +: W] = (round_ctrl.mode == MODE_HALF) ? {r_h[1], r_h[0]} : r_f;
  end

  // value being written this cycle, forwarded to the adder
  assign fwd_valid = add_valid && round_ctrl.save_to_accum;
  assign fwd_value = rnd;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      result_valid <= 1'b0;
      accum        <= '0;
    end else begin
      result_valid <= add_valid;
      if (fwd_valid) accum <= rnd;
    end
  end

  always_ff @(posedge clk) begin
    if (add_valid) result <= rnd;
  end

  // save flag must arrive with its own operation through the delay line
  assert property (@(posedge clk) disable iff (reset)
    round_ctrl.save_to_accum |-> add_valid)
    else $error("accumulator save without a valid operation");

endmodule

//--- src/valu_top.sv
// top level of the vector multiply-add unit, chains the four stages and their control delays
`include "valu_defines.svh"

module valu_top import valu_op_pkg::*, valu_ctrl_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   in_valid,
  input  vop_e                   in_op,
  input  logic                   in_frac,
  input  logic                   in_half,
  input  logic [`VALU_VEC_W-1:0] in_a,
  input  logic [`VALU_VEC_W-1:0] in_b,
  output logic                   result_valid,
  output logic [`VALU_VEC_W-1:0] result
);

  logic                                    dec_valid;
  logic [`VALU_VEC_W-1:0]                  dec_a;
  logic [`VALU_VEC_W-1:0]                  dec_b;
  logic                                    mult_by_one;
  logic                                    mult_shift;
  elem_mode_e                              mode;
  add_ctrl_t                               dec_add_ctrl;
  add_ctrl_t                               add_ctrl;
  round_ctrl_t                             dec_round_ctrl;
  round_ctrl_t                             round_ctrl;
  logic                                    mul_valid;
  logic [`VALU_NUM_ELEMS*`VALU_PROD_W-1:0] mul_p;
  logic [`VALU_VEC_W-1:0]                  mul_b;
  logic                                    add_valid;
  logic [`VALU_NUM_ELEMS*`VALU_SUM_W-1:0]  add_sum;
  logic [`VALU_VEC_W-1:0]                  accum;
  logic                                    fwd_valid;
  logic [`VALU_VEC_W-1:0]                  fwd_value;

  valu_decode valu_decode_i (
    .clk, .reset, .in_valid, .in_op, .in_frac, .in_half, .in_a, .in_b,
    .dec_valid, .dec_a, .dec_b, .mult_by_one, .mult_shift, .mode,
    .add_ctrl(dec_add_ctrl), .round_ctrl(dec_round_ctrl)
  );

  // adder controls wait one stage, rounding controls two
  ctrl_delay #(.payload_t(add_ctrl_t), .DEPTH(1)) add_ctrl_delay_i (
    .clk, .reset, .in(dec_add_ctrl), .out(add_ctrl)
  );

  ctrl_delay #(.payload_t(round_ctrl_t), .DEPTH(2)) round_ctrl_delay_i (
    .clk, .reset, .in(dec_round_ctrl), .out(round_ctrl)
  );

  valu_mult valu_mult_i (
    .clk, .reset, .dec_valid, .dec_a, .dec_b, .mult_by_one, .mult_shift, .mode,
    .mul_valid, .mul_p, .mul_b
  );

  valu_add valu_add_i (
    .clk, .reset, .mul_valid, .mul_p, .mul_b, .add_ctrl, .accum, .fwd_valid, .fwd_value,
    .add_valid, .add_sum
  );

  valu_round valu_round_i (
    .clk, .reset, .add_valid, .add_sum, .round_ctrl,
    .result_valid, .result, .accum, .fwd_valid, .fwd_value
  );

endmodule

//--- tb/valu_tb.sv
// testbench for the vector multiply-add unit, directed and random operations checked by assertions
`include "valu_defines.svh"

module valu_tb import valu_op_pkg::*;;

  localparam int NUM_DIRECTED    = 22;
  localparam int NUM_RANDOM      = 400;
  localparam int WATCHDOG_CYCLES = (NUM_DIRECTED + NUM_RANDOM) * 30 + 200;

  logic                   clk;
  logic                   reset;
  logic                   in_valid;
  vop_e                   in_op;
  logic                   in_frac;
  logic                   in_half;
  logic [`VALU_VEC_W-1:0] in_a;
  logic [`VALU_VEC_W-1:0] in_b;
  logic                   result_valid;
  logic [`VALU_VEC_W-1:0] result;

  // reference model state and expected results in issue order
  logic [`VALU_VEC_W-1:0] model_accum;
  logic [`VALU_VEC_W-1:0] exp_q [$];
  string                  name_q [$];
  logic [`VALU_VEC_W-1:0] exp_result;
  string                  exp_name;
  logic                   exp_avail;
  int                     error_count;
  int                     issued_count;
  int                     checked_count;

  valu_top valu_top_i (
    .clk, .reset, .in_valid, .in_op, .in_frac, .in_half, .in_a, .in_b,
    .result_valid, .result
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ------------------------------------------------------------
  // reference model
  // ------------------------------------------------------------

  // low ew bits of v, sign extended
  function automatic int wrap_to(int v, int ew);
    int shift;
    shift = 32 - ew;
    return (v <<< shift) >>> shift;
  endfunction

  function automatic int elem_result(vop_e op, bit frac, int ew, int a, int b, int acc);
    int m;
    int addend;
    int s;
    int max_v;
    int min_v;
    max_v = (1 << (ew - 1)) - 1;
    min_v = -(1 << (ew - 1));
    case (op)
      VOP_MUL, VOP_MULA, VOP_MULTAC: m = frac ? ((a * b) >>> (ew - 1)) : wrap_to(a * b, ew);
      default: m = a;
    endcase
    case (op)
      VOP_MULA, VOP_ADDAC: addend = acc;
      VOP_ADD: addend = b;
      VOP_SUB: addend = -b;
      default: addend = 0;
    endcase
    s = m + addend;
    if (!frac) return wrap_to(s, ew);
    if (s > max_v) return max_v;
    if (s < min_v) return min_v;
    return s;
  endfunction

  task automatic model_apply(input vop_e op, input bit frac, input bit half,
                             input logic [`VALU_VEC_W-1:0] a, input logic [`VALU_VEC_W-1:0] b,
                             output logic [`VALU_VEC_W-1:0] res);
    int off;
    int r;
    res = '0;
    for (int l = 0; l < `VALU_NUM_ELEMS; l++) begin
      if (half) begin
        for (int h = 0; h < 2; h++) begin
          off = l * `VALU_ELEM_W + h * 8;
          r = elem_result(op, frac, 8, $signed(a[off +: 8]), $signed(b[off +: 8]),
                          $signed(model_accum[off +: 8]));
          res[off +: 8] = r[7:0];
        end
      end else begin
        off = l * `VALU_ELEM_W;
        r = elem_result(op, frac, 16, $signed(a[off +: 16]), $signed(b[off +: 16]),
                        $signed(model_accum[off +: 16]));
        res[off +: 16] = r[15:0];
      end
    end
    if (op == VOP_MULTAC || op == VOP_MTAC) model_accum = res;
  endtask

  // ------------------------------------------------------------
  // stimulus helpers, called on a falling edge
  // ------------------------------------------------------------

  task automatic issue(input string name, input vop_e op, input bit frac, input bit half,
                       input logic [`VALU_VEC_W-1:0] a, input logic [`VALU_VEC_W-1:0] b);
    logic [`VALU_VEC_W-1:0] expected;
    model_apply(op, frac, half, a, b, expected);
    exp_q.push_back(expected);
    name_q.push_back(name);
    in_valid = 1'b1;
    in_op    = op;
    in_frac  = frac;
    in_half  = half;
    in_a     = a;
    in_b     = b;
    issued_count++;
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) @(negedge clk);
  endtask

  task automatic run_directed();
    issue("mul_wrap_full", VOP_MUL, 0, 0, 64'h7fff_8000_1234_ffff, 64'h0002_0003_0100_ffff);
    issue("mul_wrap_half", VOP_MUL, 0, 1, 64'h7f80_1010_ff7f_0c0d, 64'h0202_1111_ff02_f307);
    issue("add_wrap_full", VOP_ADD, 0, 0, 64'h7fff_8000_ffff_1234, 64'h0001_ffff_0001_4321);
    issue("add_wrap_half", VOP_ADD, 0, 1, 64'h7f80_7f7f_80ff_0102, 64'h01ff_0101_8001_0304);
    issue("mul_frac_full", VOP_MUL, 1, 0, 64'h8000_4000_8000_7fff, 64'h8000_4000_7fff_7fff);
    issue("mul_frac_half", VOP_MUL, 1, 1, 64'h8080_4040_807f_c07f, 64'h8080_40c0_7f7f_407f);
    // drive the accumulated fraction below the minimum
    issue("mtac_seed_min", VOP_MTAC, 1, 0, {4{16'h8000}}, '0);
    issue("mula_frac_min", VOP_MULA, 1, 0, {4{16'h8000}}, {4{16'h7fff}});
    idle(2);
    issue("sub_wrap_full", VOP_SUB, 0, 0, 64'h8000_0000_7fff_1234, 64'h0001_8000_ffff_0234);
    issue("sub_sat_full", VOP_SUB, 1, 0, 64'h8000_0000_7fff_1234, 64'h0001_8000_ffff_0234);
    issue("sub_wrap_half", VOP_SUB, 0, 1, 64'h8000_7f00_0180_5a5a, 64'h0180_ff80_8001_5aa5);
    issue("sub_sat_half", VOP_SUB, 1, 1, 64'h8000_7f00_0180_5a5a, 64'h0180_ff80_8001_5aa5);
    idle(3);
    // accumulator chain, every step one behind the last save
    issue("mtac", VOP_MTAC, 0, 0, 64'h0010_0020_fff0_1000, '0);
    issue("mula_after_mtac", VOP_MULA, 0, 0, {4{16'h0003}}, {4{16'h0005}});
    issue("multac", VOP_MULTAC, 0, 0, 64'h0007_fff9_0100_0040, 64'h0003_0003_0100_0200);
    issue("addac_after_multac", VOP_ADDAC, 0, 0, {4{16'h0100}}, '0);
    issue("multac_frac", VOP_MULTAC, 1, 0, {4{16'h4000}}, {4{16'h6000}});
    issue("mula_frac_after_multac", VOP_MULA, 1, 0, {4{16'h7fff}}, {4{16'h7fff}});
    issue("mtac_half", VOP_MTAC, 0, 1, 64'h7f80_0102_fe01_4040, '0);
    issue("addac_half", VOP_ADDAC, 1, 1, 64'h0101_7f80_8080_4040, '0);
    issue("mtac_gap", VOP_MTAC, 0, 0, 64'h1111_2222_3333_4444, '0);
    idle(1);
    issue("addac_gap", VOP_ADDAC, 0, 0, 64'h0001_0002_0003_0004, '0);
  endtask

  task automatic run_random();
    logic [2:0] op_code;
    int         gap;
    for (int i = 0; i < NUM_RANDOM; i++) begin
      op_code = $urandom_range(6, 0);
      issue($sformatf("random_%0d", i), vop_e'(op_code), $urandom_range(1, 0),
            $urandom_range(1, 0), {$urandom, $urandom}, {$urandom, $urandom});
      gap = ($urandom_range(1, 0) == 0) ? 0 : $urandom_range(3, 1);
      if (gap != 0) idle(gap);
    end
  endtask

  // ------------------------------------------------------------
  // checking
  // ------------------------------------------------------------

  // next expected value, taken while the result is stable
  always @(negedge clk) begin
    if (result_valid && exp_q.size() > 0) begin
      exp_result = exp_q.pop_front();
      exp_name   = name_q.pop_front();
      exp_avail  = 1'b1;
      checked_count++;
    end else begin
      exp_avail = 1'b0;
    end
  end

  assert property (@(posedge clk) reset |-> !result_valid)
    else begin
      error_count++;
      $display("result strobe seen while reset is asserted");
    end

  assert property (@(posedge clk) disable iff (reset)
    in_valid |-> ##(`VALU_LATENCY) result_valid)
    else begin
      error_count++;
      $display("no result strobe four cycles after an input strobe");
    end

  assert property (@(posedge clk) disable iff (reset)
    result_valid |-> $past(in_valid, `VALU_LATENCY))
    else begin
      error_count++;
      $display("result strobe without an input strobe four cycles earlier");
    end

  assert property (@(posedge clk) disable iff (reset) result_valid |-> exp_avail)
    else begin
      error_count++;
      $display("result strobe with no operation outstanding");
    end

  assert property (@(posedge clk) disable iff (reset)
    (result_valid && exp_avail) |-> (result == exp_result))
    else begin
      error_count++;
      $display("mismatch %s expected %h actual %h", exp_name, exp_result, $sampled(result));
    end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout, errors %0d, %0d of %0d results seen",
             error_count, checked_count, issued_count);
    $display("Errors found");
    $finish;
  end

  initial begin
    void'($urandom(32'h8ac9334f));
    reset         = 1'b1;
    in_valid      = 1'b0;
    in_op         = VOP_MUL;
    in_frac       = 1'b0;
    in_half       = 1'b0;
    in_a          = '0;
    in_b          = '0;
    model_accum   = '0;
    exp_result    = '0;
    exp_name      = "";
    exp_avail     = 1'b0;
    error_count   = 0;
    issued_count  = 0;
    checked_count = 0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    idle(2);
    run_directed();
    idle(4);
    run_random();
    while (checked_count < issued_count) @(posedge clk);
    repeat (2) @(posedge clk);
    $display("errors %0d, results checked %0d of %0d", error_count, checked_count, issued_count);
    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+src
src/valu_op_pkg.sv
src/valu_ctrl_pkg.sv
src/valu_decode.sv
src/ctrl_delay.sv
src/valu_mult.sv
src/valu_add.sv
src/valu_round.sv
src/valu_top.sv
tb/valu_tb.sv

//--- Bender.yml
package:
  name: valu

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/valu_op_pkg.sv
      - src/valu_ctrl_pkg.sv
      - src/valu_decode.sv
      - src/ctrl_delay.sv
      - src/valu_mult.sv
      - src/valu_add.sv
      - src/valu_round.sv
      - src/valu_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - tb/valu_tb.sv
